// File: all.f
verilog/dm_pkg.sv
verilog/dm_scratch_regs.sv
verilog/dm_hart_port.sv
verilog/dm_cmd_ctrl.sv
verilog/dm_hart_status.sv
verilog/dm_abstract_top.sv
testbench/tb_dm_abstract.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_dm_abstract -f all.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Build or simulation run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 \
    || grep -q "Simulation finished: PASS" sim.log

// File: testbench/tb_dm_abstract.sv
`timescale 1ns/1ns

module tb_dm_abstract;

    localparam int MAX_CYCLES = 600;           // Tests take about 170 cycles

    logic                dm_clk;
    logic                dm_rst_n;
    logic                dmactive;
    logic                dm_reg_wen;
    logic                dm_reg_ren;
    dm_pkg::dmi_addr_t   dm_reg_addr;
    dm_pkg::word_t       dm_reg_data;
    logic                hart_wr;
    logic                hart_rd;
    dm_pkg::hart_addr_t  hart_addr;
    dm_pkg::word_t       hart_wdata;
    dm_pkg::strb_t       hart_wstrb;
    dm_pkg::word_t       dm_abstractcs;
    dm_pkg::word_t       dm_command;
    dm_pkg::word_t       dm_data;
    dm_pkg::word_t       dm_progbuf;
    logic                halted;
    logic                resumeack;
    logic                hart_resp_valid;
    logic                hart_resp_err;
    dm_pkg::word_t       hart_rdata;

    dm_pkg::word_t m_buf [12];                 // Mirror of progbuf 0..7 and data 8..11
    logic          m_going;
    logic          m_resume_req;
    integer        seed;
    int            errors;
    int            errs_mark;
    int            tests_run;
    int            tests_failed;
    int            cycles;

    dm_abstract_top u_dm_abstract_top (.*);

    initial begin
        dm_clk = 1'b0;
        forever #20 dm_clk = ~dm_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge dm_clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic dm_pkg::word_t exp_acs(input logic busy, input dm_pkg::cmderr_t cmderr);
        dm_pkg::word_t acs;
        acs        = '0;
        acs[28:24] = 5'd8;                     // Progbuf words
        acs[12]    = busy;
        acs[10:8]  = cmderr;
        acs[3:0]   = 4'd4;                     // Data words
        return acs;
    endfunction

    function automatic dm_pkg::word_t merge_bytes(input dm_pkg::word_t old_word,
                                                  input dm_pkg::word_t new_word,
                                                  input dm_pkg::strb_t strb);
        dm_pkg::word_t res;
        int            b;
        res = old_word;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic dm_pkg::dmi_addr_t dmi_addr_of(input int i);
        return (i < 8) ? dm_pkg::DMI_PROGBUF0 + 7'(i) : dm_pkg::DMI_DATA0 + 7'(i - 8);
    endfunction

    function automatic dm_pkg::hart_addr_t hart_addr_of(input int i);
        return (i < 8) ? dm_pkg::HART_PROGBUF + 12'(4 * i) : dm_pkg::HART_DATA + 12'(4 * (i - 8));
    endfunction

    // Buffer slot behind a hart address, -1 when none
    function automatic int buf_idx_of(input dm_pkg::hart_addr_t addr);
        if (addr >= dm_pkg::HART_PROGBUF && addr < dm_pkg::HART_PROGBUF + 12'h20) begin
            return int'((addr - dm_pkg::HART_PROGBUF) >> 2);
        end
        if (addr >= dm_pkg::HART_DATA && addr < dm_pkg::HART_DATA + 12'h10) begin
            return 8 + int'((addr - dm_pkg::HART_DATA) >> 2);
        end
        return -1;
    endfunction

    // Expected {error, read data} of one hart access
    function automatic logic [32:0] ref_hart_resp(input logic wr, input dm_pkg::hart_addr_t addr);
        int            idx;
        logic          is_evt;
        logic          is_flags;
        logic          err;
        dm_pkg::word_t data;
        idx      = buf_idx_of(addr);
        is_flags = (addr == dm_pkg::HART_FLAGS);
        is_evt   = addr inside {dm_pkg::HART_HALT, dm_pkg::HART_GOING,
                                dm_pkg::HART_RESUMING, dm_pkg::HART_EXCEPTION};
        err      = wr ? !(is_evt || idx >= 0) : !(is_flags || idx >= 0);
        data     = '0;
        if (is_flags) begin
            data = {30'b0, m_resume_req, m_going};
        end else if (idx >= 0) begin
            data = m_buf[idx];
        end
        return {err, data};
    endfunction

    task automatic check_word(input string what, input dm_pkg::word_t got,
                              input dm_pkg::word_t expv);
        if (got !== expv) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expv);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != errs_mark) begin
            tests_failed++;
            $display("Test %s: failed", name);
        end else begin
            $display("Test %s: ok", name);
        end
        errs_mark = errors;
    endtask

    task automatic dmi_write(input dm_pkg::dmi_addr_t addr, input dm_pkg::word_t data);
        @(negedge dm_clk);
        dm_reg_wen  = 1'b1;
        dm_reg_addr = addr;
        dm_reg_data = data;
        @(negedge dm_clk);
        dm_reg_wen = 1'b0;
    endtask

    task automatic dmi_read_check(input dm_pkg::dmi_addr_t addr, input dm_pkg::word_t expv);
        @(negedge dm_clk);
        dm_reg_ren  = 1'b1;
        dm_reg_addr = addr;
        @(negedge dm_clk);
        check_word("DMI buffer read", (addr >= dm_pkg::DMI_PROGBUF0) ? dm_progbuf : dm_data, expv);
        dm_reg_ren = 1'b0;
    endtask

    task automatic hart_check(input logic wr, input dm_pkg::hart_addr_t addr,
                              input dm_pkg::word_t wdata, input dm_pkg::strb_t strb);
        logic [32:0] expv;
        int          idx;
        expv = ref_hart_resp(wr, addr);
        idx  = buf_idx_of(addr);
        @(negedge dm_clk);
        if (hart_resp_valid !== 1'b0) begin
            $display("Hart response valid at %0t ns with no strobe in the cycle before", $time);
            errors++;
        end
        hart_wr    = wr;
        hart_rd    = ~wr;
        hart_addr  = addr;
        hart_wdata = wdata;
        hart_wstrb = strb;
        @(negedge dm_clk);
        hart_wr = 1'b0;
        hart_rd = 1'b0;
        if (hart_resp_valid !== 1'b1) begin
            $display("Hart response to address %h missing one cycle after the strobe", addr);
            errors++;
        end else if (hart_resp_err !== expv[32]) begin
            $display("CHECK FAILED at %0t ns: hart error for %h is %b, expected %b",
                     $time, addr, hart_resp_err, expv[32]);
            errors++;
        end else if (!wr && !expv[32]) begin
            check_word("hart read data", hart_rdata, expv[31:0]);
        end
        if (wr && idx >= 0) begin
            m_buf[idx] = merge_bytes(m_buf[idx], wdata, strb);
        end
        if (wr && addr == dm_pkg::HART_GOING) begin
            m_going = 1'b0;
        end
        if (wr && addr == dm_pkg::HART_RESUMING) begin
            m_resume_req = 1'b0;
        end
    endtask

    task automatic wait_idle();
        while (dm_abstractcs[12] === 1'b1) begin
            @(negedge dm_clk);
        end
    endtask

    // Hart picks up the command, then parks again
    task automatic end_command();
        hart_check(1'b1, dm_pkg::HART_GOING, '0, '0);
        hart_check(1'b1, dm_pkg::HART_HALT, '0, '0);
        wait_idle();
    endtask

    initial begin
        dm_pkg::word_t cmd;
        int            i;
        dm_rst_n     = 1'b0;
        dmactive     = 1'b1;
        dm_reg_wen   = 1'b0;
        dm_reg_ren   = 1'b0;
        dm_reg_addr  = '0;
        dm_reg_data  = '0;
        hart_wr      = 1'b0;
        hart_rd      = 1'b0;
        hart_addr    = '0;
        hart_wdata   = '0;
        hart_wstrb   = '0;
        seed         = 32'h48c4;
        errors       = 0;
        errs_mark    = 0;
        tests_run    = 0;
        tests_failed = 0;
        m_going      = 1'b0;
        m_resume_req = 1'b0;
        for (i = 0; i < 12; i++) begin
            m_buf[i] = '0;
        end
        repeat (8) @(posedge dm_clk);
        @(negedge dm_clk);
        dm_rst_n = 1'b1;

        check_word("abstractcs", dm_abstractcs, exp_acs(1'b0, dm_pkg::CMDERR_NONE));
        check_word("command", dm_command, '0);
        check_word("halted", 32'(halted), '0);
        finish_test("reset");

        for (i = 0; i < 12; i++) begin
            m_buf[i] = $random(seed);
            dmi_write(dmi_addr_of(i), m_buf[i]);
        end
        for (i = 0; i < 12; i++) begin
            dmi_read_check(dmi_addr_of(i), m_buf[i]);
            hart_check(1'b0, hart_addr_of(i), '0, '0);
        end
        hart_check(1'b1, hart_addr_of(9), $random(seed), 4'b0101);
        hart_check(1'b1, hart_addr_of(2), $random(seed), 4'b1000);
        hart_check(1'b0, hart_addr_of(9), '0, '0);
        dmi_read_check(dmi_addr_of(2), m_buf[2]);
        finish_test("buffers");

        cmd = 32'h002A_1005;                   // 32-bit access, postincrement, transfer
        hart_check(1'b1, dm_pkg::HART_HALT, '0, '0);
        check_word("halted", 32'(halted), 32'd1);
        dmi_write(dm_pkg::DMI_COMMAND, cmd);
        m_going = 1'b1;
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b1, dm_pkg::CMDERR_NONE));
        hart_check(1'b0, dm_pkg::HART_FLAGS, '0, '0);
        hart_check(1'b1, dm_pkg::HART_GOING, '0, '0);
        hart_check(1'b0, dm_pkg::HART_FLAGS, '0, '0);
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b1, dm_pkg::CMDERR_NONE));
        hart_check(1'b1, dm_pkg::HART_HALT, '0, '0);
        wait_idle();
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b0, dm_pkg::CMDERR_NONE));
        check_word("command", dm_command, {cmd[31:16], cmd[15:0] + 16'd1});
        finish_test("command flow");

        dmi_write(dm_pkg::DMI_DMCONTROL, 32'h0000_0003);   // ndmreset drops halted
        check_word("halted", 32'(halted), '0);
        dmi_write(dm_pkg::DMI_COMMAND, 32'h0022_1000);
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b0, dm_pkg::CMDERR_HALTRESUME));
        dmi_write(dm_pkg::DMI_ABSTRACTCS, 32'h0000_0700);
        hart_check(1'b1, dm_pkg::HART_HALT, '0, '0);
        dmi_write(dm_pkg::DMI_COMMAND, 32'h0032_1000);     // aarsize 3
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b0, dm_pkg::CMDERR_NOTSUP));
        dmi_write(dm_pkg::DMI_ABSTRACTCS, 32'h0000_0700);
        dmi_write(dm_pkg::DMI_COMMAND, 32'h0022_1000);
        m_going = 1'b1;
        dmi_write(dm_pkg::DMI_DATA0, 32'hDEAD_BEEF);      // Dropped while busy
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b1, dm_pkg::CMDERR_BUSY));
        end_command();
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b0, dm_pkg::CMDERR_BUSY));
        dmi_read_check(dm_pkg::DMI_DATA0, m_buf[8]);
        dmi_write(dm_pkg::DMI_ABSTRACTCS, 32'h0000_0700);
        dmi_write(dm_pkg::DMI_COMMAND, 32'h0022_1000);
        m_going = 1'b1;
        hart_check(1'b1, dm_pkg::HART_EXCEPTION, '0, '0);
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b1, dm_pkg::CMDERR_EXCEPTION));
        dmi_write(dm_pkg::DMI_ABSTRACTCS, 32'hFFFF_FFFF);
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b1, dm_pkg::CMDERR_EXCEPTION));
        end_command();
        dmi_write(dm_pkg::DMI_ABSTRACTCS, 32'hFFFF_FFFF);
        check_word("abstractcs", dm_abstractcs, exp_acs(1'b0, dm_pkg::CMDERR_NONE));
        finish_test("cmderr");

        dmi_write(dm_pkg::DMI_DMCONTROL, 32'h4000_0001);   // resumereq
        m_resume_req = 1'b1;
        hart_check(1'b0, dm_pkg::HART_FLAGS, '0, '0);
        hart_check(1'b1, dm_pkg::HART_RESUMING, '0, '0);
        check_word("halted", 32'(halted), '0);
        check_word("resumeack", 32'(resumeack), 32'd1);
        hart_check(1'b0, dm_pkg::HART_FLAGS, '0, '0);
        dmi_write(dm_pkg::DMI_DMCONTROL, 32'h4000_0001);   // New request drops the ack
        m_resume_req = 1'b1;
        check_word("resumeack", 32'(resumeack), '0);
        hart_check(1'b0, dm_pkg::HART_FLAGS, '0, '0);
        finish_test("resume");

        hart_check(1'b0, 12'h200, '0, '0);
        hart_check(1'b1, dm_pkg::HART_FLAGS, 32'h0000_0003, 4'hF);
        hart_check(1'b0, dm_pkg::HART_HALT, '0, '0);
        finish_test("hart errors");

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/dm_abstract_top.sv
`timescale 1ns/1ns

module dm_abstract_top (
    input  logic                dm_clk,
    input  logic                dm_rst_n,
    input  logic                dmactive,
    input  logic                dm_reg_wen,
    input  logic                dm_reg_ren,
    input  dm_pkg::dmi_addr_t   dm_reg_addr,
    input  dm_pkg::word_t       dm_reg_data,
    input  logic                hart_wr,
    input  logic                hart_rd,
    input  dm_pkg::hart_addr_t  hart_addr,
    input  dm_pkg::word_t       hart_wdata,
    input  dm_pkg::strb_t       hart_wstrb,
    output dm_pkg::word_t       dm_abstractcs,
    output dm_pkg::word_t       dm_command,
    output dm_pkg::word_t       dm_data,
    output dm_pkg::word_t       dm_progbuf,
    output logic                halted,
    output logic                resumeack,
    output logic                hart_resp_valid,
    output logic                hart_resp_err,
    output dm_pkg::word_t       hart_rdata
);

    logic             busy;
    logic             going;
    logic             resume_req;
    logic             buf_dmi_access;
    logic             buf_hart_we;
    dm_pkg::buf_idx_t buf_hart_idx;
    dm_pkg::word_t    buf_hart_word;
    logic             halt_evt;
    logic             going_evt;
    logic             resuming_evt;
    logic             exception_evt;

    dm_scratch_regs u_dm_scratch_regs (
        .dm_clk         (dm_clk),
        .dm_rst_n       (dm_rst_n),
        .dmactive       (dmactive),
        .busy           (busy),
        .dm_reg_wen     (dm_reg_wen),
        .dm_reg_ren     (dm_reg_ren),
        .dm_reg_addr    (dm_reg_addr),
        .dm_reg_data    (dm_reg_data),
        .buf_hart_we    (buf_hart_we),
        .buf_hart_idx   (buf_hart_idx),
        .hart_wdata     (hart_wdata),
        .hart_wstrb     (hart_wstrb),
        .buf_hart_word  (buf_hart_word),
        .buf_dmi_access (buf_dmi_access),
        .dm_data        (dm_data),
        .dm_progbuf     (dm_progbuf)
    );

    dm_hart_port u_dm_hart_port (
        .dm_clk          (dm_clk),
        .dm_rst_n        (dm_rst_n),
        .hart_wr         (hart_wr),
        .hart_rd         (hart_rd),
        .hart_addr       (hart_addr),
        .going           (going),
        .resume_req      (resume_req),
        .buf_hart_word   (buf_hart_word),
        .buf_hart_we     (buf_hart_we),
        .buf_hart_idx    (buf_hart_idx),
        .halt_evt        (halt_evt),
        .going_evt       (going_evt),
        .resuming_evt    (resuming_evt),
        .exception_evt   (exception_evt),
        .hart_resp_valid (hart_resp_valid),
        .hart_resp_err   (hart_resp_err),
        .hart_rdata      (hart_rdata)
    );

    dm_cmd_ctrl u_dm_cmd_ctrl (
        .dm_clk         (dm_clk),
        .dm_rst_n       (dm_rst_n),
        .dmactive       (dmactive),
        .dm_reg_wen     (dm_reg_wen),
        .dm_reg_addr    (dm_reg_addr),
        .dm_reg_data    (dm_reg_data),
        .buf_dmi_access (buf_dmi_access),
        .halted         (halted),
        .halt_evt       (halt_evt),
        .going_evt      (going_evt),
        .exception_evt  (exception_evt),
        .busy           (busy),
        .going          (going),
        .dm_command     (dm_command),
        .dm_abstractcs  (dm_abstractcs)
    );

    dm_hart_status u_dm_hart_status (
        .dm_clk       (dm_clk),
        .dm_rst_n     (dm_rst_n),
        .dmactive     (dmactive),
        .dm_reg_wen   (dm_reg_wen),
        .dm_reg_addr  (dm_reg_addr),
        .dm_reg_data  (dm_reg_data),
        .halt_evt     (halt_evt),
        .resuming_evt (resuming_evt),
        .halted       (halted),
        .resumeack    (resumeack),
        .resume_req   (resume_req)
    );

endmodule

// File: verilog/dm_cmd_ctrl.sv
`timescale 1ns/1ns

module dm_cmd_ctrl (
    input  logic                dm_clk,
    input  logic                dm_rst_n,
    input  logic                dmactive,
    input  logic                dm_reg_wen,
    input  dm_pkg::dmi_addr_t   dm_reg_addr,
    input  dm_pkg::word_t       dm_reg_data,
    input  logic                buf_dmi_access,
    input  logic                halted,
    input  logic                halt_evt,
    input  logic                going_evt,
    input  logic                exception_evt,
    output logic                busy,
    output logic                going,
    output dm_pkg::word_t       dm_command,
    output dm_pkg::word_t       dm_abstractcs
);

    dm_pkg::cmd_state_t state_q;
    dm_pkg::cmderr_t    cmderr_q;
    dm_pkg::word_t      command_q;
    logic               cmd_wr;
    logic               acs_wr;
    logic               cmd_legal;
    logic               cmd_start;
    logic               cmd_done;
    logic               err_clear;

    assign busy   = (state_q == dm_pkg::CMD_RUNNING);
    assign cmd_wr = dm_reg_wen & (dm_reg_addr == dm_pkg::DMI_COMMAND);
    assign acs_wr = dm_reg_wen & (dm_reg_addr == dm_pkg::DMI_ABSTRACTCS);

    // Access register, 32-bit, known regno
    assign cmd_legal = (dm_reg_data[31:24] == 8'h00) &
                       (dm_reg_data[22:20] == 3'd2) &
                       (dm_reg_data[15:0] < dm_pkg::REGNO_LIMIT);

    assign err_clear = (cmderr_q == dm_pkg::CMDERR_NONE);
    assign cmd_start = ~busy & cmd_wr & err_clear & halted & cmd_legal;
    assign cmd_done  = busy & halt_evt & ~going;

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            state_q <= dm_pkg::CMD_IDLE;
        end else if (!dmactive) begin
            state_q <= dm_pkg::CMD_IDLE;
        end else begin
            case (state_q)
                dm_pkg::CMD_IDLE: begin
                    if (cmd_start) begin
                        state_q <= dm_pkg::CMD_RUNNING;
                    end
                end
                dm_pkg::CMD_RUNNING: begin
                    if (cmd_done) begin
                        state_q <= dm_pkg::CMD_IDLE;    // Hart parked again
                    end
                end
                default: state_q <= dm_pkg::CMD_IDLE;
            endcase
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            going <= 1'b0;
        end else if (!dmactive || going_evt) begin
            going <= 1'b0;
        end else if (cmd_start) begin
            going <= 1'b1;
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            command_q <= '0;
        end else if (!dmactive) begin
            command_q <= '0;
        end else if (cmd_done && command_q[19]) begin
            command_q[15:0] <= command_q[15:0] + 16'd1;  // Postincrement
        end else if (cmd_wr && !busy) begin
            command_q <= dm_reg_data;
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            cmderr_q <= dm_pkg::CMDERR_NONE;
        end else if (!dmactive) begin
            cmderr_q <= dm_pkg::CMDERR_NONE;
        end else if (!busy && acs_wr) begin
            cmderr_q <= cmderr_q & ~dm_reg_data[10:8];   // W1C
        end else if (err_clear && busy && exception_evt) begin
            cmderr_q <= dm_pkg::CMDERR_EXCEPTION;
        end else if (err_clear && busy && (cmd_wr || acs_wr || buf_dmi_access)) begin
            cmderr_q <= dm_pkg::CMDERR_BUSY;
        end else if (err_clear && !busy && cmd_wr && !halted) begin
            cmderr_q <= dm_pkg::CMDERR_HALTRESUME;
        end else if (err_clear && !busy && cmd_wr && !cmd_legal) begin
            cmderr_q <= dm_pkg::CMDERR_NOTSUP;
        end
    end

    assign dm_command    = command_q;
    assign dm_abstractcs = {3'b0, 5'(dm_pkg::PROGBUF_COUNT), 11'b0, busy, 1'b0,
                            cmderr_q, 4'b0, 4'(dm_pkg::DATA_COUNT)};

endmodule

// File: verilog/dm_hart_port.sv
`timescale 1ns/1ns

module dm_hart_port (
    input  logic                dm_clk,
    input  logic                dm_rst_n,
    input  logic                hart_wr,
    input  logic                hart_rd,
    input  dm_pkg::hart_addr_t  hart_addr,
    input  logic                going,
    input  logic                resume_req,
    input  dm_pkg::word_t       buf_hart_word,
    output logic                buf_hart_we,
    output dm_pkg::buf_idx_t    buf_hart_idx,
    output logic                halt_evt,
    output logic                going_evt,
    output logic                resuming_evt,
    output logic                exception_evt,
    output logic                hart_resp_valid,
    output logic                hart_resp_err,
    output dm_pkg::word_t       hart_rdata
);

    logic          evt_hit;
    logic          pb_hit;
    logic          data_hit;
    logic          flags_hit;
    logic          access_err;
    dm_pkg::word_t rd_word;

    assign pb_hit    = (hart_addr[11:5] == dm_pkg::HART_PROGBUF[11:5]);  // 8 words
    assign data_hit  = (hart_addr[11:4] == dm_pkg::HART_DATA[11:4]);     // 4 words
    assign flags_hit = (hart_addr == dm_pkg::HART_FLAGS);
    assign evt_hit   = (hart_addr == dm_pkg::HART_HALT) |
                       (hart_addr == dm_pkg::HART_GOING) |
                       (hart_addr == dm_pkg::HART_RESUMING) |
                       (hart_addr == dm_pkg::HART_EXCEPTION);

    assign buf_hart_idx = data_hit ?
                          dm_pkg::buf_idx_t'(dm_pkg::PROGBUF_COUNT) +
                          dm_pkg::buf_idx_t'(hart_addr[3:2]) :
                          dm_pkg::buf_idx_t'(hart_addr[4:2]);
    assign buf_hart_we  = hart_wr & (pb_hit | data_hit);

    assign halt_evt      = hart_wr & (hart_addr == dm_pkg::HART_HALT);
    assign going_evt     = hart_wr & (hart_addr == dm_pkg::HART_GOING);
    assign resuming_evt  = hart_wr & (hart_addr == dm_pkg::HART_RESUMING);
    assign exception_evt = hart_wr & (hart_addr == dm_pkg::HART_EXCEPTION);

    // Event words are write-only, flags is read-only
    assign access_err = hart_wr ? ~(evt_hit | pb_hit | data_hit) :
                                  ~(flags_hit | pb_hit | data_hit);

    always_comb begin
        rd_word = '0;
        if (flags_hit) begin
            rd_word = {30'b0, resume_req, going};
        end else if (pb_hit | data_hit) begin
            rd_word = buf_hart_word;
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            hart_resp_valid <= 1'b0;
            hart_resp_err   <= 1'b0;
        end else begin
            hart_resp_valid <= hart_wr | hart_rd;
            hart_resp_err   <= (hart_wr | hart_rd) & access_err;
        end
    end

    always_ff @(posedge dm_clk) begin
        if (hart_rd) begin
            hart_rdata <= rd_word;
        end
    end

endmodule

// File: verilog/dm_hart_status.sv
`timescale 1ns/1ns

module dm_hart_status (
    input  logic                dm_clk,
    input  logic                dm_rst_n,
    input  logic                dmactive,
    input  logic                dm_reg_wen,
    input  dm_pkg::dmi_addr_t   dm_reg_addr,
    input  dm_pkg::word_t       dm_reg_data,
    input  logic                halt_evt,
    input  logic                resuming_evt,
    output logic                halted,
    output logic                resumeack,
    output logic                resume_req
);

    logic dmctl_wr;
    logic resume_hit;
    logic halt_clr;

    // Only writes that keep dmactive set count
    assign dmctl_wr   = dm_reg_wen & (dm_reg_addr == dm_pkg::DMI_DMCONTROL) & dm_reg_data[0];
    assign resume_hit = dmctl_wr & dm_reg_data[30];
    assign halt_clr   = dmctl_wr & (dm_reg_data[29] | dm_reg_data[1]);   // hartreset or ndmreset

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            halted     <= 1'b0;
            resumeack  <= 1'b0;
            resume_req <= 1'b0;
        end else if (!dmactive) begin
            halted     <= 1'b0;
            resumeack  <= 1'b0;
            resume_req <= 1'b0;
        end else begin
            if (halt_evt) begin
                halted <= 1'b1;
            end else if (resuming_evt || halt_clr) begin
                halted <= 1'b0;
            end
            if (resuming_evt) begin
                resumeack  <= 1'b1;
                resume_req <= 1'b0;
            end else if (resume_hit) begin
                resumeack  <= 1'b0;
                resume_req <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/dm_pkg.sv
package dm_pkg;

    typedef logic [31:0] word_t;
    typedef logic [6:0]  dmi_addr_t;
    typedef logic [11:0] hart_addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  buf_idx_t;        // 0..7 progbuf, 8..11 data
    typedef logic [2:0]  cmderr_t;

    typedef enum logic {
        CMD_IDLE,
        CMD_RUNNING
    } cmd_state_t;

    localparam int DATA_COUNT    = 4;
    localparam int PROGBUF_COUNT = 8;
    localparam int BUF_COUNT     = PROGBUF_COUNT + DATA_COUNT;

    localparam dmi_addr_t DMI_DATA0      = 7'h04;
    localparam dmi_addr_t DMI_DMCONTROL  = 7'h10;
    localparam dmi_addr_t DMI_ABSTRACTCS = 7'h16;
    localparam dmi_addr_t DMI_COMMAND    = 7'h17;
    localparam dmi_addr_t DMI_PROGBUF0   = 7'h20;

    localparam hart_addr_t HART_HALT      = 12'h100;
    localparam hart_addr_t HART_GOING     = 12'h104;
    localparam hart_addr_t HART_RESUMING  = 12'h108;
    localparam hart_addr_t HART_EXCEPTION = 12'h10C;
    localparam hart_addr_t HART_PROGBUF   = 12'h340;
    localparam hart_addr_t HART_DATA      = 12'h380;
    localparam hart_addr_t HART_FLAGS     = 12'h400;

    localparam cmderr_t CMDERR_NONE       = 3'd0;
    localparam cmderr_t CMDERR_BUSY       = 3'd1;
    localparam cmderr_t CMDERR_NOTSUP     = 3'd2;
    localparam cmderr_t CMDERR_EXCEPTION  = 3'd3;
    localparam cmderr_t CMDERR_HALTRESUME = 3'd4;

    localparam logic [15:0] REGNO_LIMIT = 16'h1040; // First illegal regno

endpackage

// File: verilog/dm_scratch_regs.sv
`timescale 1ns/1ns

module dm_scratch_regs (
    input  logic                dm_clk,
    input  logic                dm_rst_n,
    input  logic                dmactive,
    input  logic                busy,
    input  logic                dm_reg_wen,
    input  logic                dm_reg_ren,
    input  dm_pkg::dmi_addr_t   dm_reg_addr,
    input  dm_pkg::word_t       dm_reg_data,
    input  logic                buf_hart_we,
    input  dm_pkg::buf_idx_t    buf_hart_idx,
    input  dm_pkg::word_t       hart_wdata,
    input  dm_pkg::strb_t       hart_wstrb,
    output dm_pkg::word_t       buf_hart_word,
    output logic                buf_dmi_access,
    output dm_pkg::word_t       dm_data,
    output dm_pkg::word_t       dm_progbuf
);

    dm_pkg::word_t    buf_q [dm_pkg::BUF_COUNT];
    dm_pkg::buf_idx_t dmi_idx;
    dm_pkg::word_t    hart_mask;
    dm_pkg::word_t    hart_merged;
    logic             dmi_data_hit;
    logic             dmi_pb_hit;
    logic             dmi_we;

    assign dmi_data_hit = (dm_reg_addr[6:2] == dm_pkg::DMI_DATA0[6:2]);
    assign dmi_pb_hit   = (dm_reg_addr[6:3] == dm_pkg::DMI_PROGBUF0[6:3]);

    // Data words sit above the progbuf in the combined buffer
    assign dmi_idx = dmi_data_hit ?
                     dm_pkg::buf_idx_t'(dm_pkg::PROGBUF_COUNT) +
                     dm_pkg::buf_idx_t'(dm_reg_addr[1:0]) :
                     dm_pkg::buf_idx_t'(dm_reg_addr[2:0]);

    assign dmi_we         = dm_reg_wen & ~busy & (dmi_data_hit | dmi_pb_hit);
    assign buf_dmi_access = (dm_reg_wen | dm_reg_ren) & (dmi_data_hit | dmi_pb_hit);

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            hart_mask[8*b +: 8] = {8{hart_wstrb[b]}};
        end
    end

    assign buf_hart_word = (buf_hart_idx < dm_pkg::buf_idx_t'(dm_pkg::BUF_COUNT)) ?
                           buf_q[buf_hart_idx] : '0;
    assign hart_merged   = (buf_hart_word & ~hart_mask) | (hart_wdata & hart_mask);

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            for (int i = 0; i < dm_pkg::BUF_COUNT; i++) begin
                buf_q[i] <= '0;
            end
        end else if (!dmactive) begin
            for (int i = 0; i < dm_pkg::BUF_COUNT; i++) begin
                buf_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < dm_pkg::BUF_COUNT; i++) begin
                if (dmi_we && dmi_idx == dm_pkg::buf_idx_t'(i)) begin
                    buf_q[i] <= dm_reg_data;                // Whole word
                end else if (buf_hart_we && buf_hart_idx == dm_pkg::buf_idx_t'(i)) begin
                    buf_q[i] <= hart_merged;                // Strobed bytes only
                end
            end
        end
    end

    assign dm_data    = dmi_data_hit ? buf_q[dmi_idx] : '0;
    assign dm_progbuf = dmi_pb_hit   ? buf_q[dmi_idx] : '0;

endmodule
